//--- test/adc_dma_cases.txt
# columns: window_us tready_pct sts_delay exp_bursts exp_overflow
# exp_bursts is floor(window_us * 200 / 128) unless the fifo overflows
1 100 2 1 0
2 100 5 3 0
4 50 3 6 0
5 40 4 7 0
3 100 2000 3 1
2 70 3 3 0
1 20 1 1 0

//--- src.f
+incdir+common
common/adc_capture_pkg.sv
common/s2mm_pkg.sv
common/sample_fifo_if.sv
capture/capture_fsm.sv
capture/sample_packer.sv
src/sample_fifo.sv
dma/s2mm_burst.sv
src/adc_dma_top.sv
test/tb_adc_dma_asserts.sv
test/tb_adc_dma.sv

//--- Makefile
TOP := tb_adc_dma

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module adc_dma_top

clean:
	rm -rf obj_dir

//--- test/tb_adc_dma.sv
`include "adc_dma_settings.svh"

module tb_adc_dma;
  timeunit 1ns;
  timeprecision 1ps;
  import adc_capture_pkg::*;
  import s2mm_pkg::*;

  localparam int DONE_TIMEOUT = 20000;  // covers the longest status delay

  logic                    adc_clk;
  logic                    rst;
  logic                    i_trig;
  logic [`US_BITS-1:0]     i_us_capture;
  logic [`ADC_BITS-1:0]    i_adc_data = '0;        // free-running ramp
  logic                    i_adc_or = 1'b0;
  logic                    o_cap_done;
  logic                    o_overflow;
  logic                    i_s2mm_wr_cmd_tready = 1'b0;
  logic [CMD_BITS-1:0]     o_s2mm_wr_cmd_tdata;
  logic                    o_s2mm_wr_cmd_tvalid;
  logic [`BEAT_BITS-1:0]   o_s2mm_wr_tdata;
  logic [`BEAT_BITS/8-1:0] o_s2mm_wr_tkeep;
  logic                    o_s2mm_wr_tvalid;
  logic                    o_s2mm_wr_tlast;
  logic                    i_s2mm_wr_tready = 1'b0;
  logic [TAG_BITS-1:0]     i_s2mm_sts_tdata = `S2MM_TAG;  // model only sends the good tag
  logic                    i_s2mm_sts_tvalid = 1'b0;
  logic                    i_s2mm_sts_tkeep = 1'b1;
  logic                    i_s2mm_sts_tlast = 1'b1;

  integer seed = 62;
  int     tready_pct = 100;  // per case, set at negedge
  int     sts_delay = 1;     // cycles from tlast to status
  int     exp_ovf = 0;
  int     case_no = 0;
  int     cases_run = 0;
  int     cyc = 0;           // owned by the posedge driver
  int     sts_due = -1;      // owned by the negedge monitor

  int                   mon_case = 0;
  int                   cmds_in_case = 0;
  int                   bursts_in_case = 0;
  int                   sts_in_case = 0;
  int                   dones_in_case = 0;
  int                   beat_idx = 0;
  logic                 have_prev = 1'b0;
  logic [`ADC_BITS-1:0] prev_data = '0;
  logic [`ADC_BITS-1:0] first_data;
  s2mm_cmd_u            got_cmd;
  beat_t                got_beat;

  adc_dma_top DUT (.*);

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  function automatic logic ovr_of(input logic [`ADC_BITS-1:0] d);
    return d[0] ^ d[11];  // stimulus rule for the range bit
  endfunction

  function automatic beat_t expected_beat(input logic [`ADC_BITS-1:0] first);
    beat_t                b;
    logic [`ADC_BITS-1:0] d;
    for (int i = 0; i < `SAMPLES_PER_BEAT; i++) begin
      d         = first + `ADC_BITS'(i);  // wraps at 4096
      b[i].pad  = '0;
      b[i].ovr  = ovr_of(d);
      b[i].data = d;
    end
    return b;
  endfunction

  function automatic s2mm_cmd_u expected_cmd(input int idx);
    s2mm_cmd_u c;
    c.raw     = '0;
    c.f.tag   = `S2MM_TAG;
    c.f.saddr = `DDR_BASE_ADDR + ADDR_BITS'(idx * `BLOCK_BYTES);  // base, +256, ...
    c.f.eof   = 1'b1;
    c.f.btype = CMD_TYPE_INCR;
    c.f.btt   = BTT_BITS'(`BLOCK_BYTES);
    return c;
  endfunction

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_cmd(input s2mm_pkg::s2mm_cmd_u got, input s2mm_pkg::s2mm_cmd_u exp,
                           input string what);
    if (got.raw !== exp.raw) begin
      $display("CHECK FAILED at %0t: %s got tag %h addr %h eof %b type %b btt %0d", $time,
               what, got.f.tag, got.f.saddr, got.f.eof, got.f.btype, got.f.btt);
      $display("  expected tag %h addr %h eof %b type %b btt %0d",
               exp.f.tag, exp.f.saddr, exp.f.eof, exp.f.btype, exp.f.btt);
      abort_run();
    end
  endtask

  task automatic check_beat(input adc_capture_pkg::beat_t got,
                            input adc_capture_pkg::beat_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // ramp source, random readies and delayed status
  always @(posedge adc_clk) begin
    cyc = cyc + 1;
    i_adc_data           <= i_adc_data + 12'd1;
    i_adc_or             <= ovr_of(i_adc_data + 12'd1);
    i_s2mm_wr_cmd_tready <= ($unsigned($random(seed)) % 100) < tready_pct;
    i_s2mm_wr_tready     <= ($unsigned($random(seed)) % 100) < tready_pct;
    i_s2mm_sts_tvalid    <= (cyc == sts_due);  // single-cycle status
  end

  // outputs are stable mid-cycle, a handshake seen here completes at the next posedge
  always @(negedge adc_clk) begin
    if (mon_case != case_no) begin
      mon_case       = case_no;  // new trigger, restart per-window bookkeeping
      cmds_in_case   = 0;
      bursts_in_case = 0;
      sts_in_case    = 0;
      dones_in_case  = 0;
      beat_idx       = 0;
      have_prev      = 1'b0;
    end
    if (!rst) begin
      if (o_s2mm_wr_cmd_tvalid && i_s2mm_wr_cmd_tready) begin
        got_cmd.raw = o_s2mm_wr_cmd_tdata;
        check_count(cmds_in_case, sts_in_case, "command before previous status");
        check_cmd(got_cmd, expected_cmd(cmds_in_case), "datamover command");
        cmds_in_case = cmds_in_case + 1;
      end
      if (o_s2mm_wr_tvalid && i_s2mm_wr_tready) begin
        check_count(cmds_in_case, bursts_in_case + 1, "data beat without open command");
        check_flag(&o_s2mm_wr_tkeep, 1'b1, "tkeep all ones");
        check_flag(o_s2mm_wr_tlast, beat_idx == `BLOCK_BEATS - 1, "tlast placement");
        got_beat = o_s2mm_wr_tdata;
        if (have_prev && exp_ovf == 0) begin
          first_data = prev_data + 1'b1;  // ramp continues across beats and bursts
        end else begin
          first_data = got_beat[0].data;  // drops break the ramp between beats
        end
        check_beat(got_beat, expected_beat(first_data), "sample beat");
        prev_data = got_beat[`SAMPLES_PER_BEAT-1].data;
        have_prev = 1'b1;
        if (beat_idx == `BLOCK_BEATS - 1) begin
          beat_idx       = 0;
          bursts_in_case = bursts_in_case + 1;
          sts_due        = cyc + 1 + sts_delay;
        end else begin
          beat_idx = beat_idx + 1;
        end
      end
      if (i_s2mm_sts_tvalid) begin
        sts_in_case = sts_in_case + 1;
      end
      if (o_cap_done) begin
        check_count(sts_in_case, bursts_in_case, "statuses returned before o_cap_done");
        dones_in_case = dones_in_case + 1;
      end
    end
  end

  task automatic wait_cap_done(input int limit);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(negedge adc_clk);
      seen = o_cap_done;
      n    = n + 1;
    end
    if (!seen) begin
      $display("timeout: o_cap_done did not pulse within %0d cycles", limit);
      abort_run();
    end
  endtask

  task automatic run_case(input int us, input int pct, input int dly, input int bursts,
                          input int ovf);
    @(negedge adc_clk);
    tready_pct = pct;
    @(posedge adc_clk);
    case_no   = case_no + 1;
    exp_ovf   = ovf;
    sts_delay = dly;
    i_us_capture <= `US_BITS'(us);
    i_trig       <= 1'b1;
    repeat (2) @(posedge adc_clk);
    i_trig <= 1'b0;
    repeat (3) @(posedge adc_clk);  // capture entered 3 cycles after the edge
    @(negedge adc_clk);
    check_flag(o_overflow, 1'b0, "o_overflow after trigger");
    wait_cap_done(DONE_TIMEOUT);
    check_flag(o_overflow, ovf != 0, "o_overflow at o_cap_done");
    @(posedge adc_clk);
    check_count(bursts_in_case, bursts, "bursts per window");
    check_count(cmds_in_case, bursts, "commands per window");
    repeat (2) @(posedge adc_clk);  // DONE back to IDLE
    check_count(dones_in_case, 1, "o_cap_done pulses per window");
  endtask

  initial begin
    int    fd;
    int    n;
    string line;
    int    us;
    int    pct;
    int    dly;
    int    bursts;
    int    ovf;
    rst          = 1'b1;
    i_trig       = 1'b0;
    i_us_capture = '0;
    repeat (8) @(posedge adc_clk);
    rst <= 1'b0;
    @(negedge adc_clk);
    check_flag(o_cap_done, 1'b0, "o_cap_done after reset");
    check_flag(o_overflow, 1'b0, "o_overflow after reset");
    check_flag(o_s2mm_wr_cmd_tvalid, 1'b0, "command tvalid after reset");
    check_flag(o_s2mm_wr_tvalid, 1'b0, "data tvalid after reset");
    fd = $fopen("test/adc_dma_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open test/adc_dma_cases.txt");
      abort_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%d %d %d %d %d", us, pct, dly, bursts, ovf);
        if (n == 5) begin  // comment and blank lines fall through
          run_case(us, pct, dly, bursts, ovf);
          cases_run = cases_run + 1;
        end
      end
      $fclose(fd);
      if (cases_run > 0) begin
        $display("STATUS: PASS");
        $finish;
      end else begin
        $display("no case lines found in test/adc_dma_cases.txt");
        abort_run();
      end
    end
  end

endmodule

//--- test/tb_adc_dma_asserts.sv
`include "adc_dma_settings.svh"

module tb_adc_dma_asserts (
  input logic                          adc_clk,
  input logic                          rst,
  input logic                          i_cmd_tvalid,
  input logic                          i_cmd_tready,
  input logic [s2mm_pkg::CMD_BITS-1:0] i_cmd_tdata,
  input logic                          i_wr_tvalid,
  input logic                          i_wr_tready,
  input logic [`BEAT_BITS-1:0]         i_wr_tdata,
  input logic                          i_wr_tlast,
  input logic                          i_cap_done
);
  timeunit 1ns;
  timeprecision 1ps;

  a_cmd_hold: assert property (@(posedge adc_clk) disable iff (rst)
    i_cmd_tvalid && !i_cmd_tready |=> i_cmd_tvalid && $stable(i_cmd_tdata))
    else $error("command tvalid or tdata changed before tready");

  a_data_hold: assert property (@(posedge adc_clk) disable iff (rst)
    i_wr_tvalid && !i_wr_tready |=>
      i_wr_tvalid && $stable(i_wr_tdata) && $stable(i_wr_tlast))
    else $error("data tvalid, tdata or tlast changed before tready");

  // burst closes on tlast, stream idle until the next command
  a_last_valid: assert property (@(posedge adc_clk) disable iff (rst)
    i_wr_tvalid && i_wr_tready && i_wr_tlast |=> !i_wr_tvalid)
    else $error("data tvalid still high after the tlast beat");

  a_done_pulse: assert property (@(posedge adc_clk) disable iff (rst)
    i_cap_done |=> !i_cap_done)
    else $error("o_cap_done high for two cycles");

endmodule

// top level sees the engine's stream ports and o_cap_done together
bind adc_dma_top tb_adc_dma_asserts u_asserts (
  .adc_clk      (adc_clk),
  .rst          (rst),
  .i_cmd_tvalid (o_s2mm_wr_cmd_tvalid),
  .i_cmd_tready (i_s2mm_wr_cmd_tready),
  .i_cmd_tdata  (o_s2mm_wr_cmd_tdata),
  .i_wr_tvalid  (o_s2mm_wr_tvalid),
  .i_wr_tready  (i_s2mm_wr_tready),
  .i_wr_tdata   (o_s2mm_wr_tdata),
  .i_wr_tlast   (o_s2mm_wr_tlast),
  .i_cap_done   (o_cap_done)
);

//--- src/adc_dma_top.sv
`include "adc_dma_settings.svh"

module adc_dma_top (
  input  logic                          adc_clk,
  input  logic                          rst,
  input  logic                          i_trig,
  input  logic [`US_BITS-1:0]           i_us_capture,
  input  logic [`ADC_BITS-1:0]          i_adc_data,
  input  logic                          i_adc_or,
  output logic                          o_cap_done,
  output logic                          o_overflow,
  input  logic                          i_s2mm_wr_cmd_tready,
  output logic [s2mm_pkg::CMD_BITS-1:0] o_s2mm_wr_cmd_tdata,
  output logic                          o_s2mm_wr_cmd_tvalid,
  output logic [`BEAT_BITS-1:0]         o_s2mm_wr_tdata,
  output logic [`BEAT_BITS/8-1:0]       o_s2mm_wr_tkeep,
  output logic                          o_s2mm_wr_tvalid,
  output logic                          o_s2mm_wr_tlast,
  input  logic                          i_s2mm_wr_tready,
  input  logic [s2mm_pkg::TAG_BITS-1:0] i_s2mm_sts_tdata,
  input  logic                          i_s2mm_sts_tvalid,
  input  logic                          i_s2mm_sts_tkeep,
  input  logic                          i_s2mm_sts_tlast
);

  logic sample_en; // high for every capture cycle
  logic clear;     // new trigger accepted
  logic idle;      // burst engine parked

  sample_fifo_if fifo_bus ();

  capture_fsm u_capture_fsm (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .i_trig       (i_trig),
    .i_us_capture (i_us_capture),
    .i_idle       (idle),
    .fifo         (fifo_bus.ctrl),
    .o_sample_en  (sample_en),
    .o_clear      (clear),
    .o_cap_done   (o_cap_done)
  );

  sample_packer u_sample_packer (
    .adc_clk     (adc_clk),
    .rst         (rst),
    .i_sample_en (sample_en),
    .i_clear     (clear),
    .i_adc_data  (i_adc_data),
    .i_adc_or    (i_adc_or),
    .fifo        (fifo_bus.writer)
  );

  sample_fifo u_sample_fifo (
    .adc_clk    (adc_clk),
    .rst        (rst),
    .i_clear    (clear),
    .fifo       (fifo_bus.fifo),
    .o_overflow (o_overflow)
  );

  s2mm_burst u_s2mm_burst (
    .adc_clk              (adc_clk),
    .rst                  (rst),
    .i_clear              (clear),
    .fifo                 (fifo_bus.reader),
    .i_s2mm_wr_cmd_tready (i_s2mm_wr_cmd_tready),
    .o_s2mm_wr_cmd_tdata  (o_s2mm_wr_cmd_tdata),
    .o_s2mm_wr_cmd_tvalid (o_s2mm_wr_cmd_tvalid),
    .o_s2mm_wr_tdata      (o_s2mm_wr_tdata),
    .o_s2mm_wr_tkeep      (o_s2mm_wr_tkeep),
    .o_s2mm_wr_tvalid     (o_s2mm_wr_tvalid),
    .o_s2mm_wr_tlast      (o_s2mm_wr_tlast),
    .i_s2mm_wr_tready     (i_s2mm_wr_tready),
    .i_s2mm_sts_tdata     (i_s2mm_sts_tdata),
    .i_s2mm_sts_tvalid    (i_s2mm_sts_tvalid),
    .i_s2mm_sts_tkeep     (i_s2mm_sts_tkeep),
    .i_s2mm_sts_tlast     (i_s2mm_sts_tlast),
    .o_idle               (idle)
  );

endmodule

//--- dma/s2mm_burst.sv
`include "adc_dma_settings.svh"

module s2mm_burst (
  input  logic                          adc_clk,
  input  logic                          rst,
  input  logic                          i_clear,
  sample_fifo_if.reader                 fifo,
  input  logic                          i_s2mm_wr_cmd_tready,
  output logic [s2mm_pkg::CMD_BITS-1:0] o_s2mm_wr_cmd_tdata,
  output logic                          o_s2mm_wr_cmd_tvalid,
  output logic [`BEAT_BITS-1:0]         o_s2mm_wr_tdata,
  output logic [`BEAT_BITS/8-1:0]       o_s2mm_wr_tkeep,
  output logic                          o_s2mm_wr_tvalid,
  output logic                          o_s2mm_wr_tlast,
  input  logic                          i_s2mm_wr_tready,
  input  logic [s2mm_pkg::TAG_BITS-1:0] i_s2mm_sts_tdata,
  input  logic                          i_s2mm_sts_tvalid,
  input  logic                          i_s2mm_sts_tkeep,
  input  logic                          i_s2mm_sts_tlast,
  output logic                          o_idle
);
  import s2mm_pkg::*;

  localparam int BEAT_CNT_BITS = $clog2(`BLOCK_BEATS);

  burst_state_t            state;
  burst_state_t            state_nxt;
  logic [ADDR_BITS-1:0]    addr;      // next burst start
  logic [BEAT_CNT_BITS-1:0] beat_cnt; // beats sent this burst
  s2mm_cmd_u               cmd;
  logic                    cmd_fire;
  logic                    beat_fire;
  logic                    last_beat;
  logic                    sts_ok;

  always_comb begin
    cmd.f.rsvd  = '0;
    cmd.f.tag   = `S2MM_TAG;
    cmd.f.saddr = addr;
    cmd.f.drr   = 1'b0;
    cmd.f.eof   = 1'b1;          // one frame per burst
    cmd.f.dsa   = '0;
    cmd.f.btype = CMD_TYPE_INCR;
    cmd.f.btt   = BTT_BITS'(`BLOCK_BYTES);
  end

  assign last_beat = (beat_cnt == BEAT_CNT_BITS'(`BLOCK_BEATS - 1));
  assign cmd_fire  = o_s2mm_wr_cmd_tvalid && i_s2mm_wr_cmd_tready;
  assign beat_fire = o_s2mm_wr_tvalid && i_s2mm_wr_tready;
  assign sts_ok    = i_s2mm_sts_tvalid && i_s2mm_sts_tkeep && i_s2mm_sts_tlast &&
                     (i_s2mm_sts_tdata == `S2MM_TAG); // other status ignored

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      state <= B_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      B_IDLE: if (fifo.count >= `BLOCK_BEATS) state_nxt = B_CMD;
      B_CMD:  if (cmd_fire) state_nxt = B_DATA;
      B_DATA: if (beat_fire && last_beat) state_nxt = B_WAIT;
      B_WAIT: if (sts_ok) state_nxt = B_IDLE;
      default: state_nxt = B_IDLE;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst || state != B_DATA) begin
      beat_cnt <= '0;
    end else if (beat_fire) begin
      beat_cnt <= beat_cnt + 1'b1; // wraps to 0 after tlast
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst || i_clear) begin
      addr <= `DDR_BASE_ADDR;
    end else if (state == B_WAIT && sts_ok) begin
      addr <= addr + ADDR_BITS'(`BLOCK_BYTES);
    end
  end

  assign o_s2mm_wr_cmd_tdata  = cmd.raw;             // held while in B_CMD
  assign o_s2mm_wr_cmd_tvalid = (state == B_CMD);
  assign o_s2mm_wr_tdata      = fifo.rd_data;        // head moves only on pop
  assign o_s2mm_wr_tkeep      = '1;
  assign o_s2mm_wr_tvalid     = (state == B_DATA) && !fifo.empty; // full block already queued
  assign o_s2mm_wr_tlast      = o_s2mm_wr_tvalid && last_beat;
  assign fifo.rd_en           = beat_fire;
  assign o_idle               = (state == B_IDLE);

endmodule

//--- src/sample_fifo.sv
`include "adc_dma_settings.svh"

module sample_fifo (
  input  logic        adc_clk,
  input  logic        rst,
  input  logic        i_clear,
  sample_fifo_if.fifo fifo,
  output logic        o_overflow
);
  import adc_capture_pkg::*;

  localparam int PTR_BITS = $clog2(`FIFO_DEPTH);

  beat_t               mem [`FIFO_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;
  logic                full;
  logic                wr_ok;
  logic                rd_ok;

  assign full  = (count == (PTR_BITS + 1)'(`FIFO_DEPTH));
  assign wr_ok = fifo.wr_en && !full;        // full write is lost
  assign rd_ok = fifo.rd_en && (count != '0);

  always_ff @(posedge adc_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= fifo.wr_data;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst || fifo.flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1; // pointers wrap on depth
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst || i_clear) begin
      o_overflow <= 1'b0;
    end else if (fifo.wr_en && full) begin
      o_overflow <= 1'b1; // sticky until next trigger
    end
  end

  assign fifo.rd_data = mem[rd_ptr]; // first word fall through
  assign fifo.empty   = (count == '0);
  assign fifo.count   = count;

endmodule

//--- capture/sample_packer.sv
`include "adc_dma_settings.svh"

module sample_packer (
  input  logic                 adc_clk,
  input  logic                 rst,
  input  logic                 i_sample_en,
  input  logic                 i_clear,
  input  logic [`ADC_BITS-1:0] i_adc_data,
  input  logic                 i_adc_or,
  sample_fifo_if.writer        fifo
);
  import adc_capture_pkg::*;

  localparam int LANE_BITS = $clog2(`SAMPLES_PER_BEAT);
  localparam logic [LANE_BITS-1:0] LAST_LANE = LANE_BITS'(`SAMPLES_PER_BEAT - 1);

  adc_sample_t          sample;
  beat_t                acc;      // lanes fill from 0 upward
  logic [LANE_BITS-1:0] lane;
  logic                 wr_pend;  // word complete, write next cycle

  always_comb begin
    sample.pad  = '0;
    sample.ovr  = i_adc_or;
    sample.data = i_adc_data;
  end

  always_ff @(posedge adc_clk) begin
    if (i_sample_en) begin
      acc[lane] <= sample;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst || i_clear) begin
      lane    <= '0;
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= i_sample_en && (lane == LAST_LANE);
      if (i_sample_en) begin
        lane <= (lane == LAST_LANE) ? '0 : lane + 1'b1;
      end
    end
  end

  assign fifo.wr_en   = wr_pend;
  assign fifo.wr_data = acc; // lane 0 of next word not yet overwritten

endmodule

//--- capture/capture_fsm.sv
`include "adc_dma_settings.svh"

module capture_fsm (
  input  logic                adc_clk,
  input  logic                rst,
  input  logic                i_trig,
  input  logic [`US_BITS-1:0] i_us_capture,
  input  logic                i_idle,
  sample_fifo_if.ctrl         fifo,
  output logic                o_sample_en,
  output logic                o_clear,
  output logic                o_cap_done
);
  import adc_capture_pkg::*;

  localparam int CYC_BITS = $clog2(`ADC_CYCLES_PER_US);

  logic [2:0]          trig_q;     // [1:0] sync, [2] edge history
  logic                trig_rise;
  cap_state_t          state;
  cap_state_t          state_nxt;
  logic [CYC_BITS-1:0] cyc_cnt;    // cycles within one us
  logic [`US_BITS-1:0] us_cnt;     // whole us elapsed
  logic                us_wrap;
  logic                win_end;
  logic                settle;     // first drain cycle
  logic                drain_end;

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      trig_q <= '0;
    end else begin
      trig_q <= {trig_q[1:0], i_trig};
    end
  end

  assign trig_rise = trig_q[1] & ~trig_q[2]; // no extra latency from edge detect

  assign us_wrap = (cyc_cnt == CYC_BITS'(`ADC_CYCLES_PER_US - 1));
  assign win_end = us_wrap && (us_cnt == i_us_capture - 1'b1); // last capture cycle

  // packer still holds one word on the first drain cycle
  assign drain_end = (state == DRAIN) && !settle &&
                     (fifo.count < `BLOCK_BEATS) && i_idle;

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (trig_rise) state_nxt = CAPTURE; // late triggers dropped
      CAPTURE: if (win_end) state_nxt = DRAIN;
      DRAIN:   if (drain_end) state_nxt = DONE;
      DONE:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst || state != CAPTURE) begin
      cyc_cnt <= '0;
      us_cnt  <= '0;
    end else if (us_wrap) begin
      cyc_cnt <= '0;
      us_cnt  <= us_cnt + 1'b1;
    end else begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      settle <= 1'b0;
    end else begin
      settle <= (state == CAPTURE) && win_end;
    end
  end

  assign o_clear     = (state == IDLE) && trig_rise; // lands on capture entry
  assign o_sample_en = (state == CAPTURE);
  assign o_cap_done  = (state == DONE);
  assign fifo.flush  = drain_end;                    // partial block discarded

endmodule

//--- common/sample_fifo_if.sv
`include "adc_dma_settings.svh"

interface sample_fifo_if;
  import adc_capture_pkg::*;

  logic                          wr_en;    // one packed word
  beat_t                         wr_data;
  logic                          rd_en;    // pops head, fwft
  beat_t                         rd_data;  // head of fifo
  logic                          empty;
  logic [$clog2(`FIFO_DEPTH):0]  count;    // words held
  logic                          flush;    // drop everything

  modport writer (output wr_en, output wr_data);
  modport fifo   (input wr_en, input wr_data, input rd_en, input flush,
                  output rd_data, output empty, output count);
  modport reader (output rd_en, input rd_data, input empty, input count);
  modport ctrl   (input count, output flush);

endinterface

//--- common/s2mm_pkg.sv
`include "adc_dma_settings.svh"

package s2mm_pkg;

  localparam int CMD_BITS  = 72;  // datamover command word
  localparam int ADDR_BITS = 32;
  localparam int TAG_BITS  = 4;
  localparam int BTT_BITS  = 23;

  localparam logic CMD_TYPE_INCR = 1'b1; // 0 would be fixed address

  // S2MM command layout, msb first
  typedef struct packed {
    logic [3:0]           rsvd;
    logic [TAG_BITS-1:0]  tag;    // echoed back in the status word
    logic [ADDR_BITS-1:0] saddr;  // start address
    logic                 drr;    // realignment request, unused
    logic                 eof;    // end of frame, tlast expected
    logic [5:0]           dsa;    // dre stream alignment
    logic                 btype;  // burst type
    logic [BTT_BITS-1:0]  btt;    // bytes to transfer
  } s2mm_cmd_t;

  typedef union packed {
    s2mm_cmd_t            f;    // field view
    logic [CMD_BITS-1:0]  raw;  // bus view
  } s2mm_cmd_u;

  typedef enum logic [1:0] {
    B_IDLE,  // waiting for a full block
    B_CMD,   // command offered
    B_DATA,  // streaming the block
    B_WAIT   // waiting for matching status
  } burst_state_t;

endpackage

//--- common/adc_capture_pkg.sv
`include "adc_dma_settings.svh"

package adc_capture_pkg;

  // one converter sample as stored in memory
  typedef struct packed {
    logic [`SAMPLE_BITS-`ADC_BITS-2:0] pad;  // always zero
    logic                              ovr;  // out-of-range flag
    logic [`ADC_BITS-1:0]              data; // conversion result
  } adc_sample_t;

  // sample 0 sits in bits 15:0
  typedef adc_sample_t [`SAMPLES_PER_BEAT-1:0] beat_t;

  typedef enum logic [1:0] {
    IDLE,     // waiting for trigger
    CAPTURE,  // window open, one sample per cycle
    DRAIN,    // window closed, engine finishing full blocks
    DONE      // single-cycle completion
  } cap_state_t;

endpackage

//--- common/adc_dma_settings.svh
`ifndef ADC_DMA_SETTINGS_SVH
`define ADC_DMA_SETTINGS_SVH

`define ADC_BITS          12            // converter resolution
`define SAMPLE_BITS       16            // one stored sample word
`define BEAT_BITS         64            // datamover stream width
`define SAMPLES_PER_BEAT  4             // 64 / 16
`define BLOCK_BEATS       32            // beats per burst
`define BLOCK_BYTES       256           // bytes per burst, also btt
`define FIFO_DEPTH        64            // two blocks of slack
`define ADC_CYCLES_PER_US 200           // adc_clk is 200 MHz
`define US_BITS           10            // window length field
`define S2MM_TAG          4'b1010       // cmd tag and expected status
`define DDR_BASE_ADDR     32'h34000000  // first burst lands here

`endif
